// ==== hw/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

   // ------------------------------
   // Widths and sizes
   // ------------------------------
   localparam int VADDR_W   = 23;
   localparam int CTX_W     = 3;
   localparam int PMEG_W    = 8;
   localparam int PPN_W     = 12;
   localparam int OFFS_W    = 10;
   localparam int PADDR_W   = PPN_W + OFFS_W;
   localparam int MAP_IDX_W = 12;
   localparam int NUM_LANES = 4;

   localparam logic [2:0] FC_CONTROL  = 3'd3;
   localparam logic [2:0] FC_SUP_PROG = 3'd6;

   // Word 0 is the upper half, word 1 the lower half
   typedef struct packed {
      logic             valid;
      logic [5:0]       prot;
      logic [2:0]       ptype;
      logic             acc;
      logic             mod;
      logic [3:0]       rsvd_w0;
      logic [3:0]       rsvd_w1;
      logic [PPN_W-1:0] ppn;
   } page_entry_t;

   typedef enum logic [2:0] {
      XLATE,
      PMAP0,
      PMAP1,
      SMAP,
      CONTEXT,
      ERROR_REG,
      ENABLE_REG,
      NONE
   } access_kind_e;

   typedef struct packed {
      logic [VADDR_W-1:0] addr;
      logic [2:0]         fc;
      logic               write;
      logic               uds;
      logic               lds;
      logic [15:0]        wdata;
   } cpu_req_t;

   typedef struct packed {
      access_kind_e         kind;
      cpu_req_t             req;
      logic [MAP_IDX_W-1:0] page_index;
      logic [PMEG_W-1:0]    pmeg;
      logic [15:0]          ctx_rdata;
      logic                 boot_bypass;
   } seg_stage_t;

   typedef struct packed {
      logic                 we;
      logic [MAP_IDX_W-1:0] index;
      logic [7:0]           data;
   } lane_wr_t;

   typedef struct packed {
      logic        ack;
      logic        berr;
      logic [15:0] rdata;
   } mmu_resp_t;

   typedef struct packed {
      logic [PPN_W-1:0]   ppn;
      logic [1:0]         space;
      logic               boot;
      logic [PADDR_W-1:0] paddr;
   } phys_t;

endpackage

`default_nettype wire

// ==== hw/mmu_segment_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_segment_stage
   import mmu_pkg::*;
(
   input  logic                 AS,
   input  logic                 P_RESET_n,
   input  cpu_req_t             req,
   input  logic                 req_valid,
   input  logic                 boot_state,
   output seg_stage_t           stage,
   output logic                 stage_valid,
   output logic [MAP_IDX_W-1:0] lane_index
);

   localparam int SMAP_DEPTH = 1 << MAP_IDX_W;

   access_kind_e         kind;
   logic [CTX_W-1:0]     user_ctx;
   logic [CTX_W-1:0]     sup_ctx;
   logic [CTX_W-1:0]     cur_ctx;
   logic [MAP_IDX_W-1:0] smap_index;
   logic [PMEG_W-1:0]    smap_ram [SMAP_DEPTH];
   logic [PMEG_W-1:0]    smap_rd;
   access_kind_e         kind_q;
   cpu_req_t             req_q;
   logic [15:0]          ctx_rd_q;
   logic                 bypass_q;

   // ------------------------------
   // Control space decode, A3..A1
   // ------------------------------
   always_comb
   begin
      kind = XLATE;
      if (req.fc == FC_CONTROL)
      begin
         if (!req.addr[2])
         begin
            case (req.addr[1:0])
               2'd0:    kind = PMAP0;
               2'd1:    kind = PMAP1;
               2'd2:    kind = SMAP;
               default: kind = CONTEXT;
            endcase
         end
         else if (req.addr[1:0] == 2'd2)
            kind = ERROR_REG;
         else if (req.addr[1:0] == 2'd3)
            kind = ENABLE_REG;
         else
            kind = NONE;
      end
      else if (req.fc == 3'b111)
         kind = NONE;
   end

   // Supervisor cycles use the supervisor context
   assign cur_ctx    = req.fc[2] ? sup_ctx : user_ctx;
   assign smap_index = {cur_ctx, req.addr[22:14]};

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         user_ctx    <= '0;
         sup_ctx     <= '0;
         stage_valid <= 1'b0;
      end
      else
      begin
         stage_valid <= req_valid;
         if (req_valid && kind == CONTEXT && req.write)
         begin
            if (req.lds)
               user_ctx <= req.wdata[CTX_W-1:0];
            if (req.uds)
               sup_ctx <= req.wdata[8 +: CTX_W];
         end
      end
   end

   // Segment map, one byte per entry
   always_ff @(posedge AS)
   begin
      if (req_valid)
      begin
         smap_rd <= smap_ram[smap_index];
         if (kind == SMAP && req.write && req.lds)
            smap_ram[smap_index] <= req.wdata[PMEG_W-1:0];
      end
   end

   always_ff @(posedge AS)
   begin
      if (req_valid)
      begin
         kind_q   <= kind;
         req_q    <= req;
         ctx_rd_q <= {{(8-CTX_W){1'b0}}, sup_ctx, {(8-CTX_W){1'b0}}, user_ctx};
         bypass_q <= (req.fc == FC_SUP_PROG) && boot_state;
      end
   end

   // Page map index is PMEG then A14..A11
   assign lane_index = {smap_rd, req_q.addr[13:10]};

   assign stage = '{kind:        kind_q,
                    req:         req_q,
                    page_index:  lane_index,
                    pmeg:        smap_rd,
                    ctx_rdata:   ctx_rd_q,
                    boot_bypass: bypass_q};

endmodule

`default_nettype wire

// ==== hw/page_map_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_map_lane
   import mmu_pkg::*;
(
   input  logic                 AS,
   input  logic [MAP_IDX_W-1:0] rd_index,
   input  lane_wr_t             wr,
   output logic [7:0]           rd_data
);

   localparam int LANE_DEPTH = 1 << MAP_IDX_W;

   logic [7:0] mem [LANE_DEPTH];

   // Write port, driven from the check stage
   always_ff @(posedge AS)
   begin
      if (wr.we)
         mem[wr.index] <= wr.data;
   end

   // Registered read port
   always_ff @(posedge AS)
   begin
      rd_data <= mem[rd_index];
   end

endmodule

`default_nettype wire

// ==== hw/mmu_page_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_page_check
   import mmu_pkg::*;
(
   input  logic                        AS,
   input  logic                        P_RESET_n,
   input  seg_stage_t                  stage,
   input  logic                        stage_valid,
   input  logic [NUM_LANES-1:0][7:0]   lane_data,
   output lane_wr_t [NUM_LANES-1:0]    lane_wr,
   output mmu_resp_t                   resp,
   output phys_t                       phys,
   output logic [7:0]                  sys_enable,
   output logic                        boot_state
);

   seg_stage_t                chk_q;
   logic                      chk_valid;
   page_entry_t               entry;
   logic [2:0]                rights;
   logic                      prot_ok;
   logic                      xlate;
   logic                      fault;
   logic                      is_write;
   logic [NUM_LANES-1:0]      lane_we;
   logic [NUM_LANES-1:0][7:0] lane_wdata;
   logic [15:0]               rdata;
   phys_t                     phys_next;
   logic                      ack_q;
   logic                      berr_q;
   logic [15:0]               rdata_q;
   logic [7:0]                err_q;
   logic [7:0]                enable_q;

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
         chk_valid <= 1'b0;
      else
         chk_valid <= stage_valid;
   end

   always_ff @(posedge AS)
   begin
      chk_q <= stage;
   end

   // Lane 1 and 0 form word 0, lane 3 and 2 word 1
   assign entry    = {lane_data[1], lane_data[0], lane_data[3], lane_data[2]};
   assign is_write = chk_q.req.write;
   assign xlate    = (chk_q.kind == XLATE) && !chk_q.boot_bypass;

   // ------------------------------
   // Protection check
   // ------------------------------
   assign rights = chk_q.req.fc[2] ? entry.prot[5:3] : entry.prot[2:0];

   always_comb
   begin
      case ({chk_q.req.fc[1], is_write})
         2'b00:   prot_ok = rights[2];
         2'b01:   prot_ok = rights[1];
         2'b10:   prot_ok = rights[0];
         default: prot_ok = 1'b0;
      endcase
   end

   assign fault = xlate && (!entry.valid || !prot_ok);

   // ------------------------------
   // Page map writes
   // ------------------------------
   always_comb
   begin
      lane_we = '0;
      for (int i = 0; i < NUM_LANES; i++)
         lane_wdata[i] = i[0] ? chk_q.req.wdata[15:8] : chk_q.req.wdata[7:0];
      case (chk_q.kind)
         XLATE:
         begin
            // Statistics write-back
            if (xlate && !fault)
            begin
               lane_we[0]    = 1'b1;
               lane_wdata[0] = {entry.ptype[1:0], 1'b1, entry.mod | is_write, 4'b0};
            end
         end
         PMAP0:
         begin
            lane_we[0] = is_write && chk_q.req.lds;
            lane_we[1] = is_write && chk_q.req.uds;
         end
         PMAP1:
         begin
            lane_we[2] = is_write && chk_q.req.lds;
            lane_we[3] = is_write && chk_q.req.uds;
         end
         default:
            lane_we = '0;
      endcase
      for (int i = 0; i < NUM_LANES; i++)
         lane_wr[i] = '{we: chk_valid && lane_we[i],
                        index: chk_q.page_index,
                        data: lane_wdata[i]};
   end

   // Read data, zero on writes
   always_comb
   begin
      rdata = '0;
      if (!is_write)
      begin
         case (chk_q.kind)
            PMAP0:      rdata = {entry.valid, entry.prot, entry.ptype,
                                 entry.acc, entry.mod, 4'b0};
            PMAP1:      rdata = {4'b0, entry.ppn};
            SMAP:       rdata = {8'b0, chk_q.pmeg};
            CONTEXT:    rdata = chk_q.ctx_rdata;
            ERROR_REG:  rdata = {8'b0, err_q};
            ENABLE_REG: rdata = {8'b0, enable_q};
            default:    rdata = '0;
         endcase
      end
   end

   always_comb
   begin
      if (chk_q.boot_bypass)
         phys_next = '{ppn:   chk_q.req.addr[PADDR_W-1:OFFS_W],
                       space: 2'b00,
                       boot:  1'b1,
                       paddr: chk_q.req.addr[PADDR_W-1:0]};
      else
         phys_next = '{ppn:   entry.ppn,
                       space: entry.ptype[1:0],
                       boot:  1'b0,
                       paddr: {entry.ppn, chk_q.req.addr[OFFS_W-1:0]}};
   end

   // ------------------------------
   // Response, error and enable
   // ------------------------------
   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         ack_q    <= 1'b0;
         berr_q   <= 1'b0;
         err_q    <= '0;
         enable_q <= '0;
      end
      else
      begin
         ack_q  <= chk_valid && !fault;
         berr_q <= chk_valid && fault;
         // Bit 7 invalid page, bit 3 protection
         if (chk_valid && fault)
            err_q <= {~entry.valid, 3'b000, entry.valid, 3'b000};
         if (chk_valid && chk_q.kind == ENABLE_REG && is_write && chk_q.req.lds)
            enable_q <= chk_q.req.wdata[7:0];
      end
   end

   always_ff @(posedge AS)
   begin
      rdata_q <= rdata;
      phys    <= phys_next;
   end

   assign resp       = '{ack: ack_q, berr: berr_q, rdata: rdata_q};
   assign sys_enable = enable_q;
   assign boot_state = ~enable_q[7];

endmodule

`default_nettype wire

// ==== hw/sun2_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sun2_mmu
   import mmu_pkg::*;
(
   input  logic       AS,
   input  logic       P_RESET_n,
   input  cpu_req_t   req,
   input  logic       req_valid,
   output mmu_resp_t  resp,
   output phys_t      phys,
   output logic [7:0] sys_enable
);

   seg_stage_t                stage;
   logic                      stage_valid;
   logic [MAP_IDX_W-1:0]      lane_index;
   logic [NUM_LANES-1:0][7:0] lane_data;
   lane_wr_t [NUM_LANES-1:0]  lane_wr;
   logic                      boot_state;

   mmu_segment_stage u_seg (
      .AS          (AS),
      .P_RESET_n   (P_RESET_n),
      .req         (req),
      .req_valid   (req_valid),
      .boot_state  (boot_state),
      .stage       (stage),
      .stage_valid (stage_valid),
      .lane_index  (lane_index)
   );

   // Page map, one byte lane per instance
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      page_map_lane u_lane (
         .AS       (AS),
         .rd_index (lane_index),
         .wr       (lane_wr[i]),
         .rd_data  (lane_data[i])
      );
   end

   mmu_page_check u_chk (
      .AS          (AS),
      .P_RESET_n   (P_RESET_n),
      .stage       (stage),
      .stage_valid (stage_valid),
      .lane_data   (lane_data),
      .lane_wr     (lane_wr),
      .resp        (resp),
      .phys        (phys),
      .sys_enable  (sys_enable),
      .boot_state  (boot_state)
   );

endmodule

`default_nettype wire

// ==== sim/sun2_mmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sun2_mmu_tb
   import mmu_pkg::*;
();

   localparam logic [31:0] SEED = 32'hbb35_61b4;
   // About 540 requests at 4 cycles each plus margin
   localparam int MAX_CYCLES = 6000;

   localparam logic [2:0] REG_PMAP0   = 3'd0;
   localparam logic [2:0] REG_PMAP1   = 3'd1;
   localparam logic [2:0] REG_SMAP    = 3'd2;
   localparam logic [2:0] REG_CONTEXT = 3'd3;
   localparam logic [2:0] REG_ERROR   = 3'd6;
   localparam logic [2:0] REG_ENABLE  = 3'd7;

   typedef struct packed {
      logic       xlate_ack;
      mmu_resp_t  resp;
      phys_t      phys;
      logic [7:0] enable;
   } expect_t;

   logic       AS;
   logic       P_RESET_n;
   cpu_req_t   req;
   logic       req_valid;
   mmu_resp_t  resp;
   phys_t      phys;
   logic [7:0] sys_enable;

   // Shadow model
   logic [CTX_W-1:0]  user_m;
   logic [CTX_W-1:0]  sup_m;
   logic [PMEG_W-1:0] smap_m [1 << MAP_IDX_W];
   page_entry_t       pmap_m [1 << MAP_IDX_W];
   logic [7:0]        err_m;
   logic [7:0]        en_m;

   expect_t exp_q [$];
   int      due_q [$];
   int      cycle = 0;
   int      value_errors = 0;
   int      protocol_errors = 0;
   int      timeouts = 0;
   logic    last_fault;

   sun2_mmu i_dut (
      .AS         (AS),
      .P_RESET_n  (P_RESET_n),
      .req        (req),
      .req_valid  (req_valid),
      .resp       (resp),
      .phys       (phys),
      .sys_enable (sys_enable)
   );

   initial
   begin
      AS = 1'b0;
      forever
         #20 AS = ~AS;
   end

   always @(posedge AS)
      cycle <= cycle + 1;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic access_kind_e kind_of(input cpu_req_t r);
      if (r.fc == 3'd7)
         return NONE;
      if (r.fc != FC_CONTROL)
         return XLATE;
      case (r.addr[2:0])
         3'd0:    return PMAP0;
         3'd1:    return PMAP1;
         3'd2:    return SMAP;
         3'd3:    return CONTEXT;
         3'd6:    return ERROR_REG;
         3'd7:    return ENABLE_REG;
         default: return NONE;
      endcase
   endfunction

   // Program writes never pass
   function automatic logic prot_allows(input logic [5:0] prot, input logic [2:0] fc,
                                        input logic write);
      logic [2:0] bits;
      bits = fc[2] ? prot[5:3] : prot[2:0];
      if (fc[1] && write)
         return 1'b0;
      if (fc[1])
         return bits[0];
      if (write)
         return bits[1];
      return bits[2];
   endfunction

   function automatic expect_t expected_result(input cpu_req_t r);
      expect_t      e;
      access_kind_e k;
      logic [2:0]   ctx;
      logic [7:0]   pmeg;
      page_entry_t  ent;
      e    = '0;
      k    = kind_of(r);
      ctx  = r.fc[2] ? sup_m : user_m;
      pmeg = smap_m[{ctx, r.addr[22:14]}];
      ent  = pmap_m[{pmeg, r.addr[13:10]}];
      e.resp.ack = 1'b1;
      case (k)
         XLATE:
         begin
            if (r.fc == FC_SUP_PROG && !en_m[7])
            begin
               e.xlate_ack  = 1'b1;
               e.phys.ppn   = r.addr[21:10];
               e.phys.space = 2'b00;
               e.phys.boot  = 1'b1;
               e.phys.paddr = r.addr[21:0];
            end
            else if (!ent.valid || !prot_allows(ent.prot, r.fc, r.write))
            begin
               e.resp.ack  = 1'b0;
               e.resp.berr = 1'b1;
            end
            else
            begin
               e.xlate_ack  = 1'b1;
               e.phys.ppn   = ent.ppn;
               e.phys.space = ent.ptype[1:0];
               e.phys.boot  = 1'b0;
               e.phys.paddr = {ent.ppn, r.addr[9:0]};
            end
         end
         PMAP0:      e.resp.rdata = {ent.valid, ent.prot, ent.ptype, ent.acc, ent.mod, 4'h0};
         PMAP1:      e.resp.rdata = {4'h0, ent.ppn};
         SMAP:       e.resp.rdata = {8'h00, pmeg};
         CONTEXT:    e.resp.rdata = {5'b0, sup_m, 5'b0, user_m};
         ERROR_REG:  e.resp.rdata = {8'h00, err_m};
         ENABLE_REG: e.resp.rdata = {8'h00, en_m};
         default:    e.resp.rdata = '0;
      endcase
      if (r.write)
         e.resp.rdata = '0;
      return e;
   endfunction

   task automatic update_shadow(input cpu_req_t r, input logic fault);
      access_kind_e k;
      logic [2:0]   ctx;
      logic [11:0]  sidx;
      logic [11:0]  pidx;
      k    = kind_of(r);
      ctx  = r.fc[2] ? sup_m : user_m;
      sidx = {ctx, r.addr[22:14]};
      pidx = {smap_m[sidx], r.addr[13:10]};
      case (k)
         XLATE:
         begin
            if (fault)
               err_m = pmap_m[pidx].valid ? 8'h08 : 8'h80;
            else if (!(r.fc == FC_SUP_PROG && !en_m[7]))
            begin
               pmap_m[pidx].acc = 1'b1;
               if (r.write)
                  pmap_m[pidx].mod = 1'b1;
            end
         end
         PMAP0:
         begin
            if (r.write && r.lds)
               pmap_m[pidx][23:16] = r.wdata[7:0];
            if (r.write && r.uds)
               pmap_m[pidx][31:24] = r.wdata[15:8];
         end
         PMAP1:
         begin
            if (r.write && r.lds)
               pmap_m[pidx][7:0] = r.wdata[7:0];
            if (r.write && r.uds)
               pmap_m[pidx][15:8] = r.wdata[15:8];
         end
         SMAP:
            if (r.write && r.lds)
               smap_m[sidx] = r.wdata[7:0];
         CONTEXT:
         begin
            if (r.write && r.lds)
               user_m = r.wdata[2:0];
            if (r.write && r.uds)
               sup_m = r.wdata[10:8];
         end
         ENABLE_REG:
            if (r.write && r.lds)
               en_m = r.wdata[7:0];
         default:
            ;
      endcase
   endtask

   // ------------------------------
   // Compare tasks and checker
   // ------------------------------
   task automatic check_resp(input mmu_resp_t got, input mmu_resp_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t ns: resp got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_phys(input phys_t got, input phys_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t ns: phys got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_enable(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("CHECK FAILED at %0t ns: sys_enable got %h expected %h", $time, got, exp);
      end
   endtask

   always @(negedge AS)
   begin : compare
      expect_t e;
      int      due;
      if (resp.ack || resp.berr)
      begin
         if (exp_q.size() == 0)
         begin
            protocol_errors++;
            $display("Response at %0t ns with no request outstanding", $time);
         end
         else
         begin
            e   = exp_q.pop_front();
            due = due_q.pop_front();
            if (due != cycle)
            begin
               protocol_errors++;
               $display("Response at %0t ns came in cycle %0d, not %0d", $time, cycle, due);
            end
            check_resp(resp, e.resp);
            if (e.xlate_ack)
               check_phys(phys, e.phys);
            check_enable(sys_enable, e.enable);
         end
      end
      else if (due_q.size() > 0 && cycle >= due_q[0])
      begin
         protocol_errors++;
         $display("No response at %0t ns for the request due in cycle %0d", $time, due_q[0]);
         due = due_q.pop_front();
         e   = exp_q.pop_front();
      end
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------
   task automatic run_request(input cpu_req_t r);
      expect_t e;
      int      waited;
      @(negedge AS);
      e = expected_result(r);
      update_shadow(r, e.resp.berr);
      e.enable   = en_m;
      last_fault = e.resp.berr;
      exp_q.push_back(e);
      due_q.push_back(cycle + 3);
      req       = r;
      req_valid = 1'b1;
      @(negedge AS);
      req_valid = 1'b0;
      waited    = 1;
      while (!(resp.ack || resp.berr) && waited < 6)
      begin
         @(negedge AS);
         waited++;
      end
   endtask

   task automatic control_access(input logic [2:0] sel, input logic [8:0] seg,
                                 input logic [3:0] page, input logic write,
                                 input logic [1:0] strobe, input logic [15:0] wdata);
      cpu_req_t r;
      r.addr  = {seg, page, 7'($urandom), sel};
      r.fc    = FC_CONTROL;
      r.write = write;
      r.uds   = strobe[1];
      r.lds   = strobe[0];
      r.wdata = wdata;
      run_request(r);
   endtask

   task automatic set_contexts(input logic [2:0] user, input logic [2:0] sup);
      control_access(REG_CONTEXT, '0, '0, 1'b1, 2'b11, {5'b0, sup, 5'b0, user});
   endtask

   // Segments 0..3 and pages 0..3 are the filled part of the maps
   function automatic logic [VADDR_W-1:0] mapped_addr();
      return {7'b0, 2'($urandom), 2'b0, 2'($urandom), 10'($urandom)};
   endfunction

   task automatic finish_run();
      $display("Errors: %0d value, %0d protocol, %0d timeout",
               value_errors, protocol_errors, timeouts);
      if (value_errors + protocol_errors + timeouts == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   initial
   begin : watchdog
      while (cycle < MAX_CYCLES)
         @(posedge AS);
      timeouts++;
      $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
      finish_run();
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial
   begin : stimulus
      cpu_req_t   r;
      cpu_req_t   boot_q [$];
      logic [2:0] fc;
      void'($urandom(SEED));
      P_RESET_n = 1'b0;
      req       = '0;
      req_valid = 1'b0;
      user_m    = '0;
      sup_m     = '0;
      err_m     = '0;
      en_m      = '0;
      repeat (2) @(posedge AS);
      @(negedge AS);
      P_RESET_n = 1'b1;
      check_enable(sys_enable, 8'h00);
      control_access(REG_ENABLE, '0, '0, 1'b0, 2'b11, '0);
      control_access(REG_ERROR, '0, '0, 1'b0, 2'b11, '0);
      control_access(REG_CONTEXT, '0, '0, 1'b0, 2'b11, '0);

      // Boot state bypasses translation
      repeat (6)
      begin
         r       = '0;
         r.fc    = FC_SUP_PROG;
         r.addr  = mapped_addr();
         r.write = 1'($urandom);
         r.uds   = 1'b1;
         r.lds   = 1'b1;
         r.wdata = 16'($urandom);
         boot_q.push_back(r);
         run_request(r);
      end

      for (int s = 0; s < 4; s++)
      begin
         repeat (3)
         begin
            control_access(REG_CONTEXT, '0, '0, 1'b1, 2'(s), 16'($urandom));
            control_access(REG_CONTEXT, '0, '0, 1'b0, 2'b11, '0);
         end
      end

      // Unused control codes and function code 7
      control_access(3'd4, '0, '0, 1'b0, 2'b11, '0);
      control_access(3'd5, '0, '0, 1'b1, 2'b11, 16'($urandom));
      r       = '0;
      r.fc    = 3'd7;
      r.addr  = 23'($urandom);
      r.uds   = 1'b1;
      r.lds   = 1'b1;
      run_request(r);

      // Segment map under four user contexts
      for (int c = 0; c < 4; c++)
      begin
         set_contexts(3'(c), 3'(c));
         for (int s = 0; s < 8; s++)
            control_access(REG_SMAP, 9'(s), '0, 1'b1, {1'($urandom), 1'b1}, 16'($urandom));
         control_access(REG_SMAP, 9'($urandom_range(0, 7)), '0, 1'b1, 2'b10, 16'($urandom));
      end
      for (int c = 0; c < 4; c++)
      begin
         set_contexts(3'(c), 3'(c));
         for (int s = 0; s < 8; s++)
            control_access(REG_SMAP, 9'(s), '0, 1'b0, 2'b11, '0);
      end

      // Page map fill with acc and mod clear
      for (int c = 0; c < 2; c++)
      begin
         set_contexts(3'(c), 3'(c));
         for (int i = 0; i < 16; i++)
         begin
            control_access(REG_PMAP0, 9'(i / 4), 4'(i % 4), 1'b1, 2'b11,
                           16'($urandom) & 16'hffcf);
            control_access(REG_PMAP1, 9'(i / 4), 4'(i % 4), 1'b1, 2'b11, 16'($urandom));
         end
      end

      repeat (24)
      begin
         set_contexts(3'($urandom_range(0, 1)), 3'($urandom_range(0, 1)));
         r.addr = mapped_addr();
         control_access(3'($urandom_range(0, 1)), r.addr[22:14], r.addr[13:10], 1'b1,
                        2'($urandom), 16'($urandom));
         control_access(REG_PMAP0, r.addr[22:14], r.addr[13:10], 1'b0, 2'b11, '0);
         control_access(REG_PMAP1, r.addr[22:14], r.addr[13:10], 1'b0, 2'b11, '0);
      end

      // Leave the boot state
      control_access(REG_ENABLE, '0, '0, 1'b1, 2'b10, 16'h0080);
      control_access(REG_ERROR, '0, '0, 1'b1, 2'b11, 16'($urandom) | 16'h0088);
      control_access(REG_ERROR, '0, '0, 1'b0, 2'b11, '0);
      control_access(REG_ENABLE, '0, '0, 1'b1, 2'b01, {8'($urandom), 1'b1, 7'($urandom)});
      control_access(REG_ENABLE, '0, '0, 1'b0, 2'b11, '0);
      set_contexts(3'($urandom_range(0, 1)), 3'($urandom_range(0, 1)));
      foreach (boot_q[i])
         run_request(boot_q[i]);

      for (int n = 0; n < 120; n++)
      begin
         if (n % 8 == 0)
            set_contexts(3'($urandom_range(0, 1)), 3'($urandom_range(0, 1)));
         fc = 3'($urandom_range(0, 5));
         if (fc >= FC_CONTROL)
            fc = fc + 3'd1;
         r       = '0;
         r.fc    = fc;
         r.addr  = mapped_addr();
         r.write = 1'($urandom);
         r.uds   = 1'b1;
         r.lds   = 1'b1;
         r.wdata = 16'($urandom);
         run_request(r);
         if (last_fault)
            control_access(REG_ERROR, '0, '0, 1'b0, 2'b11, '0);
         // Statistics seen through the user context
         if (!r.fc[2])
            control_access(REG_PMAP0, r.addr[22:14], r.addr[13:10], 1'b0, 2'b11, '0);
      end

      repeat (4) @(negedge AS);
      finish_run();
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/mmu_pkg.sv
hw/mmu_segment_stage.sv
hw/page_map_lane.sv
hw/mmu_page_check.sv
hw/sun2_mmu.sv
sim/sun2_mmu_tb.sv

// ==== Bender.yml ====
package:
  name: sun2_mmu

sources:
  - hw/mmu_pkg.sv
  - hw/mmu_segment_stage.sv
  - hw/page_map_lane.sv
  - hw/mmu_page_check.sv
  - hw/sun2_mmu.sv
  - target: simulation
    files:
      - sim/sun2_mmu_tb.sv
